// ==== dv/rv_core_tb.sv ====
/* random program testbench for rv_core; plays the fetch responder and the APB slave,
   loads and stores stay in the first 1 KB with x0 as base */
`default_nettype none

module rv_core_tb import rv_pkg::*; import rv_ref_model::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk = 1'b0;
  logic        reset;
  logic        fetch_req;
  logic [31:0] fetch_pc;
  fetch_rsp_t  fetch_rsp;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  retire_t     retire;

  logic [31:0] prog [prog_words];
  logic [31:0] apb_mem [256];
  logic [31:0] seed;
  int          retired;
  int          cycles;
  int          fetch_wait;
  int          apb_wait;
  int          apb_xfers;  // APB setup phases seen for the current instruction
  logic        fetch_busy;
  logic        seen_fetch;

  rv_core rv_core_inst (
    .clk       (clk),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_pc  (fetch_pc),
    .fetch_rsp (fetch_rsp),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .retire    (retire)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {seed[15:0], seed[31:16]};  // high lcg bits are the better ones
  endfunction

  function automatic logic [31:0] mem_fill(input logic [7:0] idx);
    return ({24'd0, idx} * 32'h9e3779b1) ^ {idx, idx, ~idx, 8'h5a};
  endfunction

  function automatic logic [31:0] gen_inst(input logic [7:0] idx);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] d;
    logic [2:0]  f3;
    logic [9:0]  ofs;
    logic [11:0] im;
    r1 = next_rand();
    r2 = next_rand();
    f3 = r1[17:15];
    d = ({24'd0, r2[7:0]} - {24'd0, idx}) << 2;  // branch and jal target offset
    ofs = r2[17:8];
    case (r1[21:18])
      4'd0: return {r2[31:12], r1[4:0], op_lui};
      4'd1: return {r2[31:12], r1[4:0], op_auipc};
      4'd2: return {d[20], d[10:1], d[11], d[19:12], r1[4:0], op_jal};
      4'd3: return {2'b00, r2[7:0], 2'b00, 5'd0, 3'd0, r1[4:0], op_jalr};
      4'd4, 4'd5: begin
        if (f3[2:1] == 2'b01) f3 = {1'b1, f3[1:0]};
        return {d[12], d[10:5], r1[14:10], r1[9:5], f3, d[4:1], d[11], op_branch};
      end
      4'd6, 4'd7: begin
        if (f3[1:0] == 2'b11) f3 = 3'b010;
        if (f3 == 3'b110) f3 = 3'b100;
        if (f3[1:0] == 2'b01) ofs[0] = 1'b0;
        if (f3[1:0] == 2'b10) ofs[1:0] = 2'b00;
        return {2'b00, ofs, 5'd0, f3, r1[4:0], op_load};
      end
      4'd8, 4'd9: begin
        if (f3[1:0] == 2'b11) f3[1:0] = 2'b10;
        if (f3[1:0] == 2'b01) ofs[0] = 1'b0;
        if (f3[1:0] == 2'b10) ofs[1:0] = 2'b00;
        im = {2'b00, ofs};
        return {im[11:5], r1[14:10], 5'd0, 1'b0, f3[1:0], im[4:0], op_store};
      end
      4'd10, 4'd11, 4'd12: begin
        im = r2[31:20];
        if (f3 == 3'd1) im = {7'd0, r2[4:0]};
        if (f3 == 3'd5) im = {1'b0, r2[31], 5'd0, r2[4:0]};  // srli or srai
        return {im, r1[9:5], f3, r1[4:0], op_imm};
      end
      default: return {1'b0, r2[31] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, r1[14:10],
                       r1[9:5], f3, r1[4:0], op_reg};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  always @(negedge clk) begin
    logic [31:0] w;
    logic [31:0] e_addr;
    logic [31:0] e_data;
    logic [31:0] m_wdata;
    logic [3:0]  e_strb;
    logic        e_wr;
    logic        m_we;
    logic [4:0]  m_rd;
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: only %0d instructions retired in %0d cycles", retired, cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
    if (reset) begin
      check_value("retire.valid", {31'd0, retire.valid}, 32'd0);
      check_value("apb_req.psel", {31'd0, apb_req.psel}, 32'd0);
    end

    // fetch responder
    if (fetch_req && !seen_fetch) begin
      check_value("fetch_pc", fetch_pc, 32'd0);
      seen_fetch = 1'b1;
    end
    if (fetch_rsp.valid) begin
      fetch_rsp.valid = 1'b0;
      fetch_busy = 1'b0;
    end else if (fetch_req) begin
      if (!fetch_busy) begin
        fetch_busy = 1'b1;
        fetch_wait = int'(next_rand() % 32'd3);
      end
      if (fetch_wait == 0) begin
        fetch_rsp.valid = 1'b1;
        fetch_rsp.inst = prog[fetch_pc[9:2]];
      end else begin
        fetch_wait--;
      end
    end

    // APB slave
    if (!apb_req.psel) begin
      apb_rsp.pready = 1'b0;
    end else if (!apb_req.penable) begin
      apb_wait = int'(next_rand() % 32'd4);
      apb_xfers++;
      mem_expect(prog[m_pc[9:2]], e_wr, e_addr, e_strb, e_data);
      check_value("pwrite", {31'd0, apb_req.pwrite}, {31'd0, e_wr});
      check_value("paddr", apb_req.paddr, e_addr);
      if (e_wr) begin
        check_value("pstrb", {28'd0, apb_req.pstrb}, {28'd0, e_strb});
        for (int b = 0; b < 4; b++)
          if (e_strb[b])
            check_value("pwdata lane", {24'd0, apb_req.pwdata[8*b +: 8]},
                        {24'd0, e_data[8*b +: 8]});
      end
    end else if (!apb_rsp.pready) begin
      if (apb_wait == 0) begin
        apb_rsp.pready = 1'b1;
        if (apb_req.pwrite) begin
          for (int b = 0; b < 4; b++)
            if (apb_req.pstrb[b])
              apb_mem[apb_req.paddr[9:2]][8*b +: 8] = apb_req.pwdata[8*b +: 8];
        end else begin
          apb_rsp.prdata = apb_mem[apb_req.paddr[9:2]];
        end
      end else begin
        apb_wait--;
      end
    end

    // retire checker
    if (retire.valid) begin
      w = prog[m_pc[9:2]];
      check_value("retire.pc", retire.pc, m_pc);
      check_value("apb transfers", 32'(apb_xfers),
                  (w[6:0] == op_load || w[6:0] == op_store) ? 32'd1 : 32'd0);
      apb_xfers = 0;
      step(w, m_rd, m_we, m_wdata);
      check_value("retire.rd", {27'd0, retire.rd}, {27'd0, m_rd});
      check_value("retire.we", {31'd0, retire.we}, {31'd0, m_we});
      if (m_we) check_value("retire.wdata", retire.wdata, m_wdata);
      retired++;
    end
  end

  initial begin
    reset = 1'b1;
    fetch_rsp = '0;
    apb_rsp = '0;
    seed = 32'd13199;
    retired = 0;
    cycles = 0;
    fetch_wait = 0;
    apb_wait = 0;
    apb_xfers = 0;
    fetch_busy = 1'b0;
    seen_fetch = 1'b0;
    m_pc = 32'd0;
    for (int i = 0; i < 32; i++)
      m_regs[i] = 32'd0;
    for (int i = 0; i < 256; i++) begin
      apb_mem[i] = mem_fill(8'(i));
      m_mem[i] = mem_fill(8'(i));
      prog[i] = gen_inst(8'(i));
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    wait (retired >= n_retire);
    @(negedge clk);
    $display("%0d instructions retired", retired);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/rv_ref_model.sv ====
/* instruction-set model for the testbench, covering the core's RV32I subset;
   data memory is 256 words and the address wraps inside it */
`default_nettype none

package rv_ref_model;
  import rv_pkg::*;

  localparam int n_retire    = 2000;
  localparam int cycle_limit = n_retire * 20;
  localparam int prog_words  = 256;

  logic [31:0] m_regs [32];
  logic [31:0] m_mem [256];
  logic [31:0] m_pc;

  function automatic logic [31:0] imm_i(input logic [31:0] w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic logic [31:0] imm_s(input logic [31:0] w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // expected APB transfer of a load or store
  function automatic void mem_expect(input logic [31:0] w, output logic wr,
                                     output logic [31:0] paddr, output logic [3:0] strb,
                                     output logic [31:0] data);
    logic [31:0] addr;
    logic [31:0] rs2v;
    wr = (w[6:0] == op_store);
    addr = m_regs[w[19:15]] + (wr ? imm_s(w) : imm_i(w));
    rs2v = m_regs[w[24:20]];
    paddr = {addr[31:2], 2'b00};
    case (w[13:12])
      2'd0: begin
        strb = 4'b0001 << addr[1:0];
        data = {4{rs2v[7:0]}};
      end
      2'd1: begin
        strb = 4'b0011 << addr[1:0];
        data = {2{rs2v[15:0]}};
      end
      default: begin
        strb = 4'b1111;
        data = rs2v;
      end
    endcase
  endfunction

  function automatic void step(input logic [31:0] w, output logic [4:0] rd,
                               output logic we, output logic [31:0] wdata);
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] npc;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] paddr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic        wr;
    rs1v = m_regs[w[19:15]];
    rs2v = m_regs[w[24:20]];
    rd = w[11:7];
    we = 1'b0;
    wdata = 32'd0;
    npc = m_pc + 32'd4;
    case (w[6:0])
      op_lui: begin
        we = 1'b1;
        wdata = {w[31:12], 12'd0};
      end
      op_auipc: begin
        we = 1'b1;
        wdata = m_pc + {w[31:12], 12'd0};
      end
      op_jal: begin
        we = 1'b1;
        wdata = m_pc + 32'd4;
        npc = m_pc + imm_j(w);
      end
      op_jalr: begin
        we = 1'b1;
        wdata = m_pc + 32'd4;
        npc = (rs1v + imm_i(w)) & ~32'd1;
      end
      op_branch: if (branch_cond(w[14:12], rs1v, rs2v)) npc = m_pc + imm_b(w);
      op_load: begin
        addr = rs1v + imm_i(w);
        word = m_mem[addr[9:2]] >> {addr[1:0], 3'b000};
        we = 1'b1;
        case (w[14:12])
          3'd0:    wdata = {{24{word[7]}}, word[7:0]};
          3'd1:    wdata = {{16{word[15]}}, word[15:0]};
          3'd4:    wdata = {24'd0, word[7:0]};
          3'd5:    wdata = {16'd0, word[15:0]};
          default: wdata = word;
        endcase
      end
      op_store: begin
        mem_expect(w, wr, paddr, strb, data);
        for (int b = 0; b < 4; b++)
          if (strb[b]) m_mem[paddr[9:2]][8*b +: 8] = data[8*b +: 8];
      end
      op_imm: begin
        we = 1'b1;
        wdata = alu_calc(w[14:12], w[30] && w[14:12] == 3'd5, rs1v, imm_i(w));
      end
      op_reg: begin
        we = 1'b1;
        wdata = alu_calc(w[14:12], w[30], rs1v, rs2v);
      end
      default: ;
    endcase
    we = we && (rd != 5'd0);
    if (we) m_regs[rd] = wdata;
    m_pc = npc;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/rv_alu.sv ====
/* combinational alu and branch compare; shifts use only b[4:0] */
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  alu_op_e     alu_op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [2:0]  funct3,
  output logic [31:0] result,
  output logic        branch_taken
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (alu_op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $unsigned($signed(a) >>> shamt);  // sign fill
      alu_slt:    result = {31'b0, lt_s};
      alu_sltu:   result = {31'b0, lt_u};
      alu_pass_b: result = b;
      default:    result = a + b;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  branch_taken = (a == b);
      3'b001:  branch_taken = (a != b);
      3'b100:  branch_taken = lt_s;
      3'b101:  branch_taken = !lt_s;
      3'b110:  branch_taken = lt_u;
      3'b111:  branch_taken = !lt_u;
      default: branch_taken = 1'b0;  // not a branch encoding
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
/* unpipelined RV32I core: fetch, exec, optional APB access, retire
   fetch_rsp must only answer while fetch_req is high */
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  output logic            fetch_req,
  output logic [xlen-1:0] fetch_pc,
  input  fetch_rsp_t      fetch_rsp,
  output apb_req_t        apb_req,
  input  apb_rsp_t        apb_rsp,
  output retire_t         retire
);

  typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_retire} core_state_e;

  core_state_e     state;
  logic [xlen-1:0] pc;
  inst_u           inst_q;
  logic [xlen-1:0] wb_q;       // value written back at retire
  logic [xlen-1:0] next_pc_q;
  ctrl_t           ctrl;
  logic [31:0]     imm;
  logic [31:0]     rdata1;
  logic [31:0]     rdata2;
  logic [31:0]     alu_a;
  logic [31:0]     alu_b;
  logic [31:0]     alu_result;
  logic            branch_taken;
  logic [31:0]     pc_plus4;
  logic [31:0]     pc_target;
  logic [31:0]     next_pc;
  logic            mem_access;
  logic            lsu_done;
  logic [31:0]     lsu_rdata;

  rv_decoder rv_decoder_inst (
    .inst (inst_q),
    .ctrl (ctrl),
    .imm  (imm)
  );

  rv_regfile rv_regfile_inst (
    .clk    (clk),
    .reset  (reset),
    .rs1    (inst_q.r_fmt.rs1),
    .rs2    (inst_q.r_fmt.rs2),
    .rd     (inst_q.r_fmt.rd),
    .we     (state == st_retire && ctrl.reg_write),
    .wdata  (wb_q),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  assign alu_a = ctrl.alu_a_pc ? pc : rdata1;
  assign alu_b = ctrl.alu_src_imm ? imm : rdata2;

  rv_alu rv_alu_inst (
    .alu_op       (ctrl.alu_op),
    .a            (alu_a),
    .b            (alu_b),
    .funct3       (inst_q.r_fmt.funct3),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  assign mem_access = ctrl.mem_read || ctrl.mem_write;

  rv_lsu rv_lsu_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (state == st_exec && mem_access),
    .write       (ctrl.mem_write),
    .addr        (alu_result),
    .wdata       (rdata2),
    .size        (ctrl.mem_size),
    .is_unsigned (ctrl.mem_unsigned),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .done        (lsu_done),
    .rdata       (lsu_rdata)
  );

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    case (ctrl.jump)
      jmp_jal:    next_pc = pc_target;
      jmp_jalr:   next_pc = {alu_result[31:1], 1'b0};
      jmp_branch: next_pc = branch_taken ? pc_target : pc_plus4;
      default:    next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_fetch;
      pc        <= '0;
      fetch_req <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          fetch_req <= !fetch_rsp.valid;
          if (fetch_rsp.valid) state <= st_exec;
        end
        st_exec: state <= mem_access ? st_mem : st_retire;
        st_mem:  if (lsu_done) state <= st_retire;
        default: begin
          pc        <= next_pc_q;
          fetch_req <= 1'b1;  // next fetch starts right after the retire pulse
          state     <= st_fetch;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch && fetch_rsp.valid)
      inst_q <= fetch_rsp.inst;
    if (state == st_exec) begin
      next_pc_q <= next_pc;
      case (ctrl.wb_sel)
        wb_alu:  wb_q <= alu_result;
        wb_pc4:  wb_q <= pc_plus4;
        default: wb_q <= alu_result;  // loads overwrite it in st_mem
      endcase
    end
    if (state == st_mem && lsu_done && ctrl.wb_sel == wb_mem)
      wb_q <= lsu_rdata;
  end

  assign fetch_pc = pc;

  always_comb begin
    retire.valid = (state == st_retire);
    retire.pc    = pc;
    retire.rd    = inst_q.r_fmt.rd;
    retire.wdata = wb_q;
    retire.we    = ctrl.reg_write && (inst_q.r_fmt.rd != 5'd0);  // x0 writes are dropped
  end

endmodule

`default_nettype wire

// ==== rtl/rv_decoder.sv ====
/* control decode for the RV32I subset; unknown opcodes give an all-zero control word
   (no write, no memory access, pc plus 4) */
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  inst_u       inst,
  output ctrl_t       ctrl,
  output logic [31:0] imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;  // funct7 bit 5, selects sub / sra

  assign opcode = inst.r_fmt.opcode;
  assign funct3 = inst.r_fmt.funct3;
  assign alt    = inst.r_fmt.funct7[5];

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sel_alt);
    case (f3)
      3'b000:  return sel_alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return sel_alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    ctrl.wb_sel = wb_alu;
    ctrl.jump = jmp_none;
    ctrl.mem_unsigned = funct3[2];
    case (funct3[1:0])
      2'b00:   ctrl.mem_size = mem_byte;
      2'b01:   ctrl.mem_size = mem_half;
      default: ctrl.mem_size = mem_word;
    endcase

    case (opcode)
      op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op = alu_pass_b;
      end
      op_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_a_pc = 1'b1;
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel = wb_pc4;
        ctrl.jump = jmp_jal;
      end
      op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;  // alu forms rs1 + imm
        ctrl.wb_sel = wb_pc4;
        ctrl.jump = jmp_jalr;
      end
      op_branch: ctrl.jump = jmp_branch;
      op_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb_sel = wb_mem;
      end
      op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op = alu_from_f3(funct3, alt && (funct3 == 3'b101));
      end
      op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = alu_from_f3(funct3, alt);
      end
      default: ;
    endcase
  end

  always_comb begin
    case (opcode)
      op_lui, op_auipc: imm = {inst.u_fmt.imm_31_12, 12'b0};
      op_jal: imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                     inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
      op_branch: imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                        inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
      op_store: imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
      default: imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_lsu.sv ====
/* APB master for one load or store at a time; misaligned accesses just use the
   lanes given by addr[1:0], and pslverr is not looked at */
`default_nettype none

module rv_lsu import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic        write,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  mem_size_e   size,
  input  logic        is_unsigned,
  output apb_req_t    apb_req,
  input  apb_rsp_t    apb_rsp,
  output logic        done,
  output logic [31:0] rdata
);

  typedef enum logic [1:0] {lsu_idle, lsu_setup, lsu_access} lsu_state_e;

  lsu_state_e  state;
  logic [1:0]  lane_q;
  mem_size_e   size_q;
  logic        unsigned_q;
  logic        pwrite_q;
  logic [31:0] paddr_q;
  logic [31:0] pwdata_q;
  logic [3:0]  pstrb_q;
  logic [31:0] shifted;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= lsu_idle;
    end else begin
      case (state)
        lsu_idle:   if (start) state <= lsu_setup;
        lsu_setup:  state <= lsu_access;
        lsu_access: if (apb_rsp.pready) state <= lsu_idle;
        default:    state <= lsu_idle;
      endcase
    end
  end

  // transfer payload, held for the whole transfer
  always_ff @(posedge clk) begin
    if (state == lsu_idle && start) begin
      lane_q     <= addr[1:0];
      size_q     <= size;
      unsigned_q <= is_unsigned;
      pwrite_q   <= write;
      paddr_q    <= {addr[31:2], 2'b00};
      case (size)
        mem_byte: begin
          pwdata_q <= {4{wdata[7:0]}};
          pstrb_q  <= 4'b0001 << addr[1:0];
        end
        mem_half: begin
          pwdata_q <= {2{wdata[15:0]}};
          pstrb_q  <= 4'b0011 << addr[1:0];
        end
        default: begin
          pwdata_q <= wdata;
          pstrb_q  <= 4'b1111;
        end
      endcase
    end
  end

  always_comb begin
    apb_req.psel    = (state != lsu_idle);
    apb_req.penable = (state == lsu_access);
    apb_req.pwrite  = pwrite_q;
    apb_req.paddr   = paddr_q;
    apb_req.pwdata  = pwdata_q;
    apb_req.pstrb   = pstrb_q;
  end

  assign done    = (state == lsu_access) && apb_rsp.pready;
  assign shifted = apb_rsp.prdata >> {lane_q, 3'b000};

  always_comb begin
    case (size_q)
      mem_byte: rdata = {{24{!unsigned_q && shifted[7]}}, shifted[7:0]};
      mem_half: rdata = {{16{!unsigned_q && shifted[15]}}, shifted[15:0]};
      default:  rdata = apb_rsp.prdata;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
/* shared RV32I types for the core, covering the decoded subset only (no MUL, CSR or FENCE)
   mem_size_e follows the 00 word / 01 half / 10 byte encoding */
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  localparam logic [1:0] wb_alu = 2'd0;
  localparam logic [1:0] wb_mem = 2'd1;
  localparam logic [1:0] wb_pc4 = 2'd2;

  localparam logic [1:0] jmp_none   = 2'd0;
  localparam logic [1:0] jmp_jal    = 2'd1;
  localparam logic [1:0] jmp_jalr   = 2'd2;
  localparam logic [1:0] jmp_branch = 2'd3;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
    alu_pass_b // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_word = 2'b00,
    mem_half = 2'b01,
    mem_byte = 2'b10
  } mem_size_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, viewed per format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      alu_src_imm;  // b operand is the immediate
    logic      alu_a_pc;     // a operand is the pc
    logic [1:0] wb_sel;
    logic [1:0] jump;
    alu_op_e   alu_op;
    mem_size_e mem_size;
    logic      mem_unsigned;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    inst_u inst;
  } fetch_rsp_t;

  typedef struct packed {
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [xlen-1:0] paddr;
    logic [xlen-1:0] pwdata;
    logic [3:0]      pstrb;
  } apb_req_t;

  typedef struct packed {
    logic            pready;
    logic [xlen-1:0] prdata;
  } apb_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic [xlen-1:0] wdata;
    logic            we;
  } retire_t;

endpackage

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
/* 32 x 32 register file, combinational reads; x0 reads zero and ignores writes */
`default_nettype none

module rv_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [31:1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module rv_core_tb -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// ==== vlog.f ====
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
dv/rv_ref_model.sv
dv/rv_core_tb.sv
